//--- sim.f
+incdir+hdl
hdl/pad_pkg.sv
hdl/serial_pkg.sv
hdl/button_encoder.sv
hdl/code_fifo.sv
hdl/uart_tx.sv
hdl/pad_led_top.sv
sim/tb_pad_led.sv

//--- Makefile
# Verilator simulation of the game-pad LED reporter

VERILATOR ?= verilator
TOP       ?= tb_pad_led
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timescale 1ns/1ns -j $(JOBS)
PASS_MSG  ?= Test OK

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_pad_led.sv
`timescale 1ns/1ns
`include "pad_led_settings.svh"

module tb_pad_led
    import pad_pkg::*;
();

    localparam int CLK_NS     = 4;
    localparam int CPB        = `PAD_CLKS_PER_BIT;
    localparam int BIT_NS     = CPB * CLK_NS;
    localparam int DEPTH      = `PAD_FIFO_DEPTH;
    localparam int MAX_CYCLES = 2000;

    logic         i_clk;
    logic         i_rstn;
    button_word_t i_buttons;
    led_code_t    o_led;
    logic         o_tx;
    logic         o_tx_busy;
    logic         o_overflow;

    integer    seed;
    int        errors;
    int        tests_run;
    int        cycles = 0;
    led_code_t model_code;
    led_code_t rx_bytes[$];
    led_code_t exp_bytes[$];

    pad_led_top uut (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_buttons  (i_buttons),
        .o_led      (o_led),
        .o_tx       (o_tx),
        .o_tx_busy  (o_tx_busy),
        .o_overflow (o_overflow)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
    end

    // Run limit
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Serial monitor
    ////////////////////////////////////////

    // Each bit is sampled on a falling clock edge just past its middle
    initial begin : serial_monitor
        led_code_t data;
        wait (i_rstn === 1'b1);
        forever begin
            @(negedge o_tx);
            #(BIT_NS / 2 + CLK_NS / 2);
            for (int b = 0; b < 8; b++) begin
                #(BIT_NS);
                data[b] = o_tx;
            end
            #(BIT_NS);
            if (o_tx !== 1'b1) begin
                $display("Framing error: stop bit low after byte 0x%02h", data);
                errors++;
            end
            rx_bytes.push_back(data);
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Lowest pressed button in 1..33 or else the old code
    function automatic led_code_t expected_code(input button_word_t w, input led_code_t prev);
        led_code_t code;
        logic      found;
        code  = prev;
        found = 1'b0;
        for (int i = 1; i < `PAD_NUM_BUTTONS; i++) begin
            if (w[i] && !found) begin
                code  = led_code_t'(i);
                found = 1'b1;
            end
        end
        return code;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_word(input button_word_t w);
        @(posedge i_clk);
        #1;
        i_buttons = w;
    endtask

    // Code shows up two edges after the word is driven
    task automatic encode_and_check(input button_word_t w);
        led_code_t exp;
        exp = expected_code(w, model_code);
        apply_word(w);
        repeat (2) @(posedge i_clk);
        #1;
        check_value("o_led", 64'(o_led), 64'(exp));
        if (exp != model_code) begin
            exp_bytes.push_back(exp);
        end
        model_code = exp;
    endtask

    // Line idle for a few cycles in a row means the queue is empty too
    task automatic wait_drained;
        int idle_run;
        idle_run = 0;
        repeat (4) @(posedge i_clk);
        while (idle_run < 3) begin
            @(posedge i_clk);
            #1;
            idle_run = o_tx_busy ? 0 : idle_run + 1;
        end
    endtask

    task automatic compare_bytes;
        check_value("byte count", 64'(rx_bytes.size()), 64'(exp_bytes.size()));
        for (int k = 0; k < rx_bytes.size() && k < exp_bytes.size(); k++) begin
            check_value("o_tx byte", 64'(rx_bytes[k]), 64'(exp_bytes[k]));
        end
        rx_bytes.delete();
        exp_bytes.delete();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        $display("%s finished with %0d error(s)", name, errors - errs_before);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reset_state;
        int e0;
        e0 = errors;
        check_value("o_led", 64'(o_led), 64'h0);
        check_value("o_tx", 64'(o_tx), 64'h1);
        check_value("o_tx_busy", 64'(o_tx_busy), 64'h0);
        check_value("o_overflow", 64'(o_overflow), 64'h0);
        finish_test("reset_state", e0);
    endtask

    task automatic test_priority;
        int           e0;
        int           shift;
        logic [63:0]  r;
        button_word_t w;
        e0 = errors;
        encode_and_check(34'h0_0010_0220);
        wait_drained();
        encode_and_check(34'h2_0002_0000);
        wait_drained();
        // Bit 0 set along with 12 and 31
        encode_and_check(34'h0_8000_1001);
        wait_drained();
        encode_and_check(34'h2_0000_0000);
        wait_drained();
        for (int n = 0; n < 4; n++) begin
            r     = {$random(seed), $random(seed)};
            shift = $unsigned($random(seed)) % 32;
            w     = r[33:0] & ({`PAD_NUM_BUTTONS{1'b1}} << shift);
            encode_and_check(w);
            wait_drained();
        end
        compare_bytes();
        finish_test("priority", e0);
    endtask

    task automatic test_serial_report;
        int e0;
        e0 = errors;
        encode_and_check(34'h0_0000_0408);
        wait_drained();
        compare_bytes();
        encode_and_check(34'h0_4000_0000);
        wait_drained();
        compare_bytes();
        finish_test("serial_report", e0);
    endtask

    // Starts from code 30
    task automatic test_hold;
        int e0;
        e0 = errors;
        encode_and_check(34'h0_0000_0000);
        encode_and_check(34'h0_0000_0001);
        encode_and_check(34'h1_4000_0000);
        wait_drained();
        compare_bytes();
        finish_test("hold", e0);
    endtask

    task automatic test_queue_overflow;
        int e0;
        e0 = errors;
        for (int k = 0; k < DEPTH + 3; k++) begin
            apply_word(button_word_t'(1) << (20 + k));
            repeat (2) @(posedge i_clk);
            #1;
            // Nothing dropped while the queue still has room
            if (k <= DEPTH) begin
                exp_bytes.push_back(led_code_t'(20 + k));
                check_value("o_overflow", 64'(o_overflow), 64'h0);
            end
        end
        model_code = led_code_t'(20 + DEPTH + 2);
        check_value("o_led", 64'(o_led), 64'(model_code));
        check_value("o_overflow", 64'(o_overflow), 64'h1);
        wait_drained();
        compare_bytes();
        finish_test("queue_overflow", e0);
    endtask

    initial begin
        seed       = 32'h0cf3_8f45;
        errors     = 0;
        tests_run  = 0;
        model_code = '0;
        i_rstn     = 1'b0;
        i_buttons  = '0;
        repeat (8) @(posedge i_clk);
        #1;
        i_rstn = 1'b1;

        test_reset_state();
        test_priority();
        test_serial_report();
        test_hold();
        test_queue_overflow();

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/pad_led_top.sv
`timescale 1ns/1ns
`include "pad_led_settings.svh"

module pad_led_top
    import pad_pkg::*;
    import serial_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rstn,
    input  button_word_t i_buttons,
    output led_code_t    o_led,
    output logic         o_tx,
    output logic         o_tx_busy,
    output logic         o_overflow
);

    code_update_t update;
    led_code_t    head_code;
    logic         fifo_empty;
    logic         fifo_full;
    logic         pop;
    tx_status_t   tx_status;

    // Buttons to LED code
    button_encoder u_encoder (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_buttons  (i_buttons),
        .i_full     (fifo_full),
        .o_led      (o_led),
        .o_update   (update),
        .o_overflow (o_overflow)
    );

    // Codes waiting for the serial line
    code_fifo #(
        .DEPTH (`PAD_FIFO_DEPTH)
    ) u_fifo (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .i_update  (update),
        .i_pop     (pop),
        .o_rd_data (head_code),
        .o_empty   (fifo_empty),
        .o_full    (fifo_full)
    );

    // 8N1 report of each code
    uart_tx u_tx (
        .i_clk    (i_clk),
        .i_rstn   (i_rstn),
        .i_data   (head_code),
        .i_empty  (fifo_empty),
        .o_pop    (pop),
        .o_tx     (o_tx),
        .o_status (tx_status)
    );

    assign o_tx_busy = tx_status.busy;

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ns
`include "pad_led_settings.svh"

module uart_tx
    import pad_pkg::*;
    import serial_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rstn,
    input  led_code_t  i_data,
    input  logic       i_empty,
    output logic       o_pop,
    output logic       o_tx,
    output tx_status_t o_status
);

    localparam int CPB   = `PAD_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB + 1);

    tx_state_e        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    led_code_t        shift_q;
    logic             tx_q;
    logic             done_q;
    logic             bit_end;

    // Last cycle of the current bit period
    assign bit_end = (bit_cnt == CNT_W'(CPB - 1));

    // Take the head of the queue as soon as the line is free
    assign o_pop = (state == TX_IDLE) && !i_empty;

    // Data shifter, LSB goes out first
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            shift_q <= i_data;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_q    <= 1'b1;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state != TX_IDLE) begin
                bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                    if (o_pop) begin
                        tx_q  <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tx_q    <= shift_q[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx_q  <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            // Next bit, before the shift lands
                            tx_q    <= shift_q[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        done_q <= 1'b1;
                        state  <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign o_tx          = tx_q;
    assign o_status.busy = (state != TX_IDLE);
    assign o_status.done = done_q;

endmodule

//--- hdl/code_fifo.sv
`timescale 1ns/1ns

module code_fifo
    import pad_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic         i_clk,
    input  logic         i_rstn,
    input  code_update_t i_update,
    input  logic         i_pop,
    output led_code_t    o_rd_data,
    output logic         o_empty,
    output logic         o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    led_code_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;

    // Writer checks full before raising valid
    assign wr_en = i_update.valid;

    // Storage
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_update.code;
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous write and pop leave the count alone
            case ({wr_en, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word is always visible
    assign o_rd_data = mem[rd_ptr];
    assign o_empty   = (count == '0);
    assign o_full    = (count == CNT_W'(DEPTH));

endmodule

//--- hdl/button_encoder.sv
`timescale 1ns/1ns
`include "pad_led_settings.svh"

module button_encoder
    import pad_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rstn,
    input  button_word_t i_buttons,
    input  logic         i_full,
    output led_code_t    o_led,
    output code_update_t o_update,
    output logic         o_overflow
);

    button_word_t btn_q;
    led_code_t    next_code;
    logic         code_changed;

    // Input register
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            btn_q <= '0;
        end else begin
            btn_q <= i_buttons;
        end
    end

    ////////////////////////////////////////
    // Priority encoder
    ////////////////////////////////////////

    // Scan from the top so the lowest set index is the last to win;
    // bit 0 is never looked at and an empty word keeps the old code
    always_comb begin
        next_code = o_led;
        for (int i = `PAD_NUM_BUTTONS - 1; i >= 1; i--) begin
            if (btn_q[i]) begin
                next_code = led_code_t'(i);
            end
        end
    end

    assign code_changed = (next_code != o_led);

    // LED code, queue strobe and sticky overflow
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_led      <= '0;
            o_update   <= '0;
            o_overflow <= 1'b0;
        end else begin
            o_update.valid <= 1'b0;
            if (code_changed) begin
                o_led          <= next_code;
                o_update.code  <= next_code;
                // Queue full, the LEDs still follow but the byte is lost
                o_update.valid <= !i_full;
                if (i_full) begin
                    o_overflow <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/serial_pkg.sv
package serial_pkg;

    ////////////////////////////////////////
    // 8N1 transmitter
    ////////////////////////////////////////

    // Frame phases
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

    // busy covers the whole frame, done pulses after the stop bit
    typedef struct packed {
        logic busy;
        logic done;
    } tx_status_t;

endpackage

//--- hdl/pad_pkg.sv
`include "pad_led_settings.svh"

package pad_pkg;

    ////////////////////////////////////////
    // Game-pad side
    ////////////////////////////////////////

    // Raw button word from the pad, one bit per button
    typedef logic [`PAD_NUM_BUTTONS-1:0] button_word_t;

    // Index of the winning button, shown on the LEDs
    typedef logic [7:0] led_code_t;

    ////////////////////////////////////////
    // Encoder to queue
    ////////////////////////////////////////

    // valid is a single-cycle strobe
    typedef struct packed {
        logic      valid;
        led_code_t code;
    } code_update_t;

endpackage

//--- hdl/pad_led_settings.svh
`ifndef PAD_LED_SETTINGS_SVH
`define PAD_LED_SETTINGS_SVH

// System clock in Hz
`define PAD_CLK_FREQ_HZ 50000000

// Serial bit rate, kept high so a byte is only a few dozen cycles
`define PAD_BAUD_RATE 12500000

// Clock cycles per serial bit
`define PAD_CLKS_PER_BIT (`PAD_CLK_FREQ_HZ / `PAD_BAUD_RATE)

// Number of LED codes the queue can hold
`define PAD_FIFO_DEPTH 4

// Width of the game-pad button word, bit 0 unused
`define PAD_NUM_BUTTONS 34

`endif
